//--- all.f
+incdir+bench
source/aluOpsPkg.sv
source/instFormatPkg.sv
source/regBusIf.sv
source/registerFile.sv
source/barrelShifter.sv
source/alu.sv
source/execControl.sv
source/execUnit.sv
bench/execUnitTb.sv

//--- bench/execChecks.svh
`ifndef execChecksSvh
`define execChecksSvh

////////////////////////////////////////
// Failure exit and compare tasks
////////////////////////////////////////

task automatic abortRun(input string reason);
	$display("%s", reason);
	$display("*** TEST FAILED ***");
	$fatal(1, "Simulation stopped at %0t ns", $time);
endtask

// Data word from the result register
task automatic checkResult(
	input logic [dataWidth-1:0] got,
	input logic [dataWidth-1:0] expected,
	input string name
);
	if (got !== expected)
		abortRun($sformatf("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got,
			expected));
endtask

// Status register as seen on the flags port
task automatic checkFlags(
	input aluOpsPkg::aluFlags got,
	input aluOpsPkg::aluFlags expected,
	input string name
);
	if (got !== expected)
		abortRun($sformatf("[ERROR] %0t ns %s: got %b, expected %b (c f l n z)", $time,
			name, got, expected));
endtask

task automatic checkBadOp(
	input logic got,
	input logic expected,
	input string name
);
	if (got !== expected)
		abortRun($sformatf("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got,
			expected));
endtask

`endif

//--- bench/execUnitTb.sv
`timescale 1ns/1ns

module execUnitTb;

	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int maxLines = 128;
	localparam int fieldCount = 7;

	logic clk = 1'b0;
	logic rst;
	logic instValid;
	aluOpsPkg::aluOp opcode;
	instFormatPkg::regIndex dst;
	instFormatPkg::regIndex src;
	instFormatPkg::immWord imm;
	logic resultValid;
	logic [dataWidth-1:0] result;
	aluOpsPkg::aluFlags flags;
	logic badOp;

	// One 16-bit word per column of the stimulus file
	logic [15:0] stimMem [0:fieldCount*maxLines-1];
	int lineCount = 0;
	int issuedCount = 0;
	int checkedCount = 0;
	int cycleCount = 0;
	int cycleLimit = 1000;
	logic checking = 1'b0;

	// Reference state
	logic [dataWidth-1:0] modelRegs [regCount];
	aluOpsPkg::aluFlags modelStatus;

	`include "execChecks.svh"

	execUnit #(
		.dataWidth(dataWidth),
		.regCount (regCount)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.instValid  (instValid),
		.opcode     (opcode),
		.dst        (dst),
		.src        (src),
		.imm        (imm),
		.resultValid(resultValid),
		.result     (result),
		.flags      (flags),
		.badOp      (badOp)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic logic isKnown(input aluOpsPkg::aluOp op);
		case (op)
			aluOpsPkg::ADD, aluOpsPkg::ADDU, aluOpsPkg::ADDI, aluOpsPkg::ADDUI,
			aluOpsPkg::ADDCU, aluOpsPkg::ADDCUI, aluOpsPkg::SUB, aluOpsPkg::SUBI,
			aluOpsPkg::CMP, aluOpsPkg::CMPI, aluOpsPkg::TEST, aluOpsPkg::AND,
			aluOpsPkg::OR, aluOpsPkg::XOR, aluOpsPkg::NOT, aluOpsPkg::LSH,
			aluOpsPkg::LSHI, aluOpsPkg::RSH, aluOpsPkg::RSHI, aluOpsPkg::ALSH,
			aluOpsPkg::ARSH, aluOpsPkg::NOP:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic takesImm(input aluOpsPkg::aluOp op);
		return op inside {aluOpsPkg::ADDI, aluOpsPkg::ADDUI, aluOpsPkg::ADDCUI,
			aluOpsPkg::SUBI, aluOpsPkg::LSHI, aluOpsPkg::RSHI, aluOpsPkg::CMPI};
	endfunction

	task automatic modelAlu(
		input aluOpsPkg::aluOp op,
		input logic [dataWidth-1:0] a,
		input logic [dataWidth-1:0] b,
		input logic cin,
		output logic [dataWidth-1:0] res,
		output aluOpsPkg::aluFlags fl
	);
		int sa;
		int sb;
		int sr;
		int sMax;
		logic withCin;
		logic [dataWidth:0] uSum;
		sa = $signed(a);
		sb = $signed(b);
		sMax = (1 << (dataWidth - 1)) - 1;
		withCin = op inside {aluOpsPkg::ADDCU, aluOpsPkg::ADDCUI};
		res = '0;
		fl = '0;
		case (op)
			aluOpsPkg::ADD, aluOpsPkg::ADDI, aluOpsPkg::SUB, aluOpsPkg::SUBI:
			begin
				sr = (op inside {aluOpsPkg::SUB, aluOpsPkg::SUBI}) ? sa - sb : sa + sb;
				res = dataWidth'(sr);
				fl.flag = (sr > sMax) || (sr < -sMax - 1);
				fl.low = sa < sb;
				fl.negative = res[dataWidth-1];
				fl.zero = (res == 0);
			end
			aluOpsPkg::ADDU, aluOpsPkg::ADDUI, aluOpsPkg::ADDCU, aluOpsPkg::ADDCUI:
			begin
				uSum = a + b + (withCin & cin);
				res = uSum[dataWidth-1:0];
				fl.carry = uSum[dataWidth];
				fl.low = a < b;
				fl.zero = (res == 0) && !(withCin && fl.carry);
			end
			aluOpsPkg::CMP, aluOpsPkg::CMPI:
			begin
				fl.low = a < b;
				fl.negative = sa < sb;
				fl.zero = (a == b);
			end
			aluOpsPkg::TEST, aluOpsPkg::AND, aluOpsPkg::OR, aluOpsPkg::XOR:
			begin
				res = (op == aluOpsPkg::OR) ? (a | b) : (op == aluOpsPkg::XOR) ? (a ^ b) : (a & b);
				fl.low = a < b;
				fl.negative = sa < sb;
				fl.zero = (res == 0);
			end
			aluOpsPkg::NOT:
			begin
				res = ~a;
				fl.low = res < a;
				fl.negative = res[dataWidth-1];
				fl.zero = (res == 0);
			end
			aluOpsPkg::RSH, aluOpsPkg::RSHI:
			begin
				res = (b >= dataWidth) ? '0 : a >> b;
				fl.zero = (res == 0);
			end
			aluOpsPkg::ARSH:
			begin
				// Sign copies fill from the top
				if (b >= dataWidth)
					res = {dataWidth{a[dataWidth-1]}};
				else
					res = $signed(a) >>> b;
				fl.zero = (res == 0);
			end
			aluOpsPkg::LSH, aluOpsPkg::LSHI, aluOpsPkg::ALSH:
			begin
				res = (b >= dataWidth) ? '0 : a << b;
				fl.zero = (res == 0);
			end
			default:
				res = '0;
		endcase
	endtask

	// One instruction through the model, returns what the ports should show
	task automatic modelStep(
		input int line,
		output logic [dataWidth-1:0] expResult,
		output aluOpsPkg::aluFlags expFlags,
		output logic expBad
	);
		aluOpsPkg::aluOp op;
		logic [dataWidth-1:0] b;
		aluOpsPkg::aluFlags aluFl;
		op = aluOpsPkg::aluOp'(stimMem[fieldCount*line][7:0]);
		b = takesImm(op) ? stimMem[fieldCount*line+3] : modelRegs[stimMem[fieldCount*line+2][3:0]];
		modelAlu(op, modelRegs[stimMem[fieldCount*line+1][3:0]], b, modelStatus.carry,
			expResult, aluFl);
		expBad = !isKnown(op);
		if (expBad)
			expResult = '0;
		else if (op != aluOpsPkg::NOP)
		begin
			if (!(op inside {aluOpsPkg::CMP, aluOpsPkg::CMPI}))
				modelRegs[stimMem[fieldCount*line+1][3:0]] = expResult;
			modelStatus = aluFl;
		end
		expFlags = modelStatus;
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial
	begin
		logic [dataWidth-1:0] mRes;
		aluOpsPkg::aluFlags mFl;
		logic mBad;
		int base;
		rst = 1'b1;
		instValid = 1'b0;
		opcode = aluOpsPkg::NOP;
		dst = '0;
		src = '0;
		imm = '0;
		$readmemh("execUnit_stim.txt", stimMem);
		while (lineCount < maxLines && !$isunknown(stimMem[fieldCount*lineCount]))
			lineCount++;
		if (lineCount == 0)
			abortRun("Stimulus file execUnit_stim.txt is missing or holds no lines");
		cycleLimit = 3 + lineCount + 20;

		// File expectations must agree with the model before the DUT is run
		for (int r = 0; r < regCount; r++)
			modelRegs[r] = '0;
		modelStatus = '0;
		for (int i = 0; i < lineCount; i++)
		begin
			base = fieldCount * i;
			modelStep(i, mRes, mFl, mBad);
			if (mRes !== stimMem[base+4] || mFl !== stimMem[base+5][4:0]
				|| mBad !== stimMem[base+6][0])
				abortRun($sformatf(
					"Stimulus line %0d expects %h/%b/%b but the model gives %h/%b/%b",
					i + 1, stimMem[base+4], stimMem[base+5][4:0], stimMem[base+6][0],
					mRes, mFl, mBad));
		end

		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (resultValid !== 1'b0)
			abortRun($sformatf("[ERROR] %0t ns resultValid: got %b, expected 0", $time,
				resultValid));
		checkResult(result, '0, "result after reset");
		checkFlags(flags, '0, "flags after reset");
		checkBadOp(badOp, 1'b0, "badOp after reset");
		checking = 1'b1;

		// Back-to-back, one instruction per cycle
		for (int i = 0; i < lineCount; i++)
		begin
			base = fieldCount * i;
			@(posedge clk);
			instValid <= 1'b1;
			opcode <= aluOpsPkg::aluOp'(stimMem[base][7:0]);
			dst <= stimMem[base+1][3:0];
			src <= stimMem[base+2][3:0];
			imm <= stimMem[base+3];
			issuedCount++;
		end
		@(posedge clk);
		instValid <= 1'b0;

		// Stray pulses in the last cycles stop the run from the checker
		wait (checkedCount == lineCount);
		repeat (2) @(negedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

	////////////////////////////////////////
	// Output checking and timeout
	////////////////////////////////////////

	always @(negedge clk)
	begin : checkOutputs
		int base;
		if (checking && resultValid === 1'b1)
		begin
			if (checkedCount >= issuedCount)
				abortRun("resultValid pulsed with no instruction in flight");
			else
			begin
				base = fieldCount * checkedCount;
				checkResult(result, stimMem[base+4], $sformatf("result, instruction %0d",
					checkedCount + 1));
				checkFlags(flags, aluOpsPkg::aluFlags'(stimMem[base+5][4:0]),
					$sformatf("flags, instruction %0d", checkedCount + 1));
				checkBadOp(badOp, stimMem[base+6][0], $sformatf("badOp, instruction %0d",
					checkedCount + 1));
				checkedCount++;
			end
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
			abortRun($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
				cycleCount, checkedCount, lineCount));
	end

endmodule

//--- execUnit_stim.txt
// op dst src imm | expected result, flags {carry flag low negative zero}, badOp
// all values hex, one instruction per line, issued back to back
50 1 0 7FF0 7FF0 04 0
50 2 0 0020 0020 04 0
05 1 2 0000 8010 0A 0
09 2 1 0000 8010 0A 0
90 2 0 8010 0000 01 0
50 3 0 FFFF FFFF 02 0
06 3 1 0000 800F 10 0
70 3 0 7FF0 0000 10 0
07 2 3 0000 0001 00 0
07 3 3 0000 0000 01 0
0B 1 2 0000 0000 02 0
B0 2 0 0001 0000 01 0
0A 1 1 0000 8010 00 0
05 1 2 0000 8011 06 0
50 4 0 0F0F 0F0F 04 0
50 5 0 00FF 00FF 04 0
01 4 5 0000 000F 00 0
02 4 5 0000 00FF 06 0
03 4 5 0000 0000 01 0
0F 5 0 0000 FF00 02 0
0F 1 0 0000 7FEE 04 0
80 5 0 0000 FF00 00 0
88 5 0 0005 07F8 00 0
50 7 0 000F 000F 04 0
50 8 0 9000 9000 02 0
8E 8 7 0000 FFFF 00 0
84 5 7 0000 0000 01 0
50 9 0 0010 0010 04 0
50 A 0 8421 8421 02 0
8E A 9 0000 FFFF 00 0
8C A 9 0000 0000 01 0
50 B 0 A5A5 A5A5 02 0
80 B 0 0005 B4A0 00 0
8E B 0 0000 B4A0 00 0
50 C 0 0005 0005 04 0
8E B C 0000 FDA5 00 0
86 C C 0000 00A0 00 0
B0 C 0 00A0 0000 01 0
00 C 0 0000 0000 01 0
44 C 0 1234 0000 01 1
05 C 0 0000 00A0 00 0

//--- source/alu.sv
`timescale 1ns/1ns

module alu #(
	parameter int dataWidth = 16
)(
	input aluOpsPkg::aluOp op,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input logic carryIn,
	output logic [dataWidth-1:0] result,
	output aluOpsPkg::aluFlags flags
);

	localparam int msb = dataWidth - 1;

	aluOpsPkg::shiftKind kind;
	logic [dataWidth-1:0] shifted;
	logic [dataWidth-1:0] sum;
	logic [dataWidth-1:0] diff;
	logic carryOut;
	logic useCarry;
	logic addOverflow;
	logic subOverflow;
	logic signedLess;
	logic unsignedLess;

	barrelShifter #(
		.dataWidth(dataWidth)
	) shifter (
		.value  (a),
		.amount (b),
		.kind   (kind),
		.shifted(shifted)
	);

	always_comb
	begin
		case (op)
			aluOpsPkg::RSH, aluOpsPkg::RSHI: kind = aluOpsPkg::shiftRight;
			aluOpsPkg::ARSH: kind = aluOpsPkg::shiftArith;
			default: kind = aluOpsPkg::shiftLeft;
		endcase
	end

	////////////////////////////////////////
	// Shared adder, subtractor, compares
	////////////////////////////////////////

	assign useCarry = (op == aluOpsPkg::ADDCU) || (op == aluOpsPkg::ADDCUI);
	assign {carryOut, sum} = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, useCarry & carryIn};
	assign diff = a - b;

	// Signed overflow when the operand signs disagree with the result
	assign addOverflow = (~a[msb] & ~b[msb] & sum[msb]) | (a[msb] & b[msb] & ~sum[msb]);
	assign subOverflow = (~a[msb] & b[msb] & diff[msb]) | (a[msb] & ~b[msb] & ~diff[msb]);

	assign signedLess = $signed(a) < $signed(b);
	assign unsignedLess = a < b;

	////////////////////////////////////////
	// Result and flags per opcode
	////////////////////////////////////////

	always_comb
	begin
		result = '0;
		flags = '0;
		case (op)
			aluOpsPkg::ADD, aluOpsPkg::ADDI:
			begin
				result = sum;
				flags.flag = addOverflow;
				flags.low = signedLess;
				flags.negative = sum[msb];
				flags.zero = (sum == '0);
			end
			aluOpsPkg::ADDU, aluOpsPkg::ADDUI:
			begin
				result = sum;
				flags.carry = carryOut;
				flags.low = unsignedLess;
				flags.zero = (sum == '0);
			end
			aluOpsPkg::ADDCU, aluOpsPkg::ADDCUI:
			begin
				result = sum;
				flags.carry = carryOut;
				flags.low = unsignedLess;
				// Zero only if nothing carried out either
				flags.zero = (sum == '0) && !carryOut;
			end
			aluOpsPkg::SUB, aluOpsPkg::SUBI:
			begin
				result = diff;
				flags.flag = subOverflow;
				flags.low = signedLess;
				flags.negative = diff[msb];
				flags.zero = (diff == '0);
			end
			aluOpsPkg::CMP, aluOpsPkg::CMPI:
			begin
				flags.low = unsignedLess;
				flags.negative = signedLess;
				flags.zero = (a == b);
			end
			aluOpsPkg::TEST, aluOpsPkg::AND, aluOpsPkg::OR, aluOpsPkg::XOR:
			begin
				if (op == aluOpsPkg::OR)
					result = a | b;
				else if (op == aluOpsPkg::XOR)
					result = a ^ b;
				else
					result = a & b;
				flags.low = unsignedLess;
				flags.negative = signedLess;
				flags.zero = (result == '0);
			end
			aluOpsPkg::NOT:
			begin
				result = ~a;
				flags.low = (~a) < a;
				flags.negative = ~a[msb];
				flags.zero = (a == '1);
			end
			aluOpsPkg::LSH, aluOpsPkg::LSHI, aluOpsPkg::ALSH, aluOpsPkg::RSH,
			aluOpsPkg::RSHI, aluOpsPkg::ARSH:
			begin
				result = shifted;
				flags.zero = (shifted == '0);
			end
			// NOP and unknown codes leave everything at zero
			default:
			begin
				result = '0;
				flags = '0;
			end
		endcase
	end

endmodule

//--- source/aluOpsPkg.sv
package aluOpsPkg;

	////////////////////////////////////////
	// Opcode encodings
	////////////////////////////////////////

	// Register forms in the low nibble, immediate forms in the high nibble
	typedef enum logic [7:0] {
		NOP    = 8'h00,
		AND    = 8'h01,
		OR     = 8'h02,
		XOR    = 8'h03,
		ADD    = 8'h05,
		ADDU   = 8'h06,
		ADDCU  = 8'h07,
		SUB    = 8'h09,
		TEST   = 8'h0A,
		CMP    = 8'h0B,
		NOT    = 8'h0F,
		ADDI   = 8'h50,
		ADDUI  = 8'h60,
		ADDCUI = 8'h70,
		LSHI   = 8'h80,
		LSH    = 8'h84,
		ALSH   = 8'h86,
		RSHI   = 8'h88,
		RSH    = 8'h8C,
		ARSH   = 8'h8E,
		SUBI   = 8'h90,
		CMPI   = 8'hB0
	} aluOp;

	////////////////////////////////////////
	// Condition flags
	////////////////////////////////////////

	typedef struct packed {
		logic carry;
		logic flag;
		logic low;
		logic negative;
		logic zero;
	} aluFlags;

	// Shift direction and fill
	typedef enum logic [1:0] {
		shiftLeft  = 2'd0,
		shiftRight = 2'd1,
		shiftArith = 2'd2
	} shiftKind;

endpackage

//--- source/barrelShifter.sv
`timescale 1ns/1ns

module barrelShifter #(
	parameter int dataWidth = 16
)(
	input logic [dataWidth-1:0] value,
	input logic [dataWidth-1:0] amount,
	input aluOpsPkg::shiftKind kind,
	output logic [dataWidth-1:0] shifted
);

	localparam int stageCount = $clog2(dataWidth);

	logic fillBit;
	logic outOfRange;
	logic [dataWidth-1:0] level;
	logic [2*dataWidth-1:0] wide;

	// Sign copies only for the arithmetic shift
	assign fillBit = (kind == aluOpsPkg::shiftArith) ? value[dataWidth-1] : 1'b0;

	// Any bit above the stage bits shifts everything out
	assign outOfRange = |amount[dataWidth-1:stageCount];

	// One stage per amount bit, each a fixed power-of-two shift
	always_comb
	begin
		level = value;
		wide = '0;
		for (int s = 0; s < stageCount; s++)
		begin
			if (amount[s])
			begin
				if (kind == aluOpsPkg::shiftLeft)
					level = level << (1 << s);
				else
				begin
					wide = {{dataWidth{fillBit}}, level} >> (1 << s);
					level = wide[dataWidth-1:0];
				end
			end
		end
	end

	assign shifted = outOfRange ? {dataWidth{fillBit}} : level;

endmodule

//--- source/execControl.sv
`timescale 1ns/1ns

module execControl #(
	parameter int dataWidth = 16
)(
	input logic clk,
	input logic rst,
	input logic instValid,
	input aluOpsPkg::aluOp opcode,
	input instFormatPkg::regIndex dst,
	input instFormatPkg::regIndex src,
	input instFormatPkg::immWord imm,
	regBusIf.client bus,
	output aluOpsPkg::aluOp aluOpOut,
	output logic [dataWidth-1:0] opA,
	output logic [dataWidth-1:0] opB,
	output logic carryIn,
	input logic [dataWidth-1:0] aluResult,
	input aluOpsPkg::aluFlags aluFlagsIn,
	output logic resultValid,
	output logic [dataWidth-1:0] result,
	output aluOpsPkg::aluFlags flags,
	output logic badOp
);

	instFormatPkg::operandSrc bSel;
	logic known;
	logic writeReg;
	logic updateFlags;
	aluOpsPkg::aluFlags status;

	////////////////////////////////////////
	// Opcode decode
	////////////////////////////////////////

	always_comb
	begin
		known = 1'b1;
		bSel = instFormatPkg::srcReg;
		writeReg = 1'b1;
		updateFlags = 1'b1;
		case (opcode)
			aluOpsPkg::ADDI, aluOpsPkg::ADDUI, aluOpsPkg::ADDCUI, aluOpsPkg::SUBI,
			aluOpsPkg::LSHI, aluOpsPkg::RSHI:
				bSel = instFormatPkg::srcImm;
			aluOpsPkg::CMPI:
			begin
				bSel = instFormatPkg::srcImm;
				writeReg = 1'b0;
			end
			aluOpsPkg::CMP:
				writeReg = 1'b0;
			aluOpsPkg::NOP:
			begin
				writeReg = 1'b0;
				updateFlags = 1'b0;
			end
			aluOpsPkg::ADD, aluOpsPkg::ADDU, aluOpsPkg::ADDCU, aluOpsPkg::SUB,
			aluOpsPkg::TEST, aluOpsPkg::AND, aluOpsPkg::OR, aluOpsPkg::XOR,
			aluOpsPkg::NOT, aluOpsPkg::LSH, aluOpsPkg::RSH, aluOpsPkg::ALSH,
			aluOpsPkg::ARSH:
				bSel = instFormatPkg::srcReg;
			// Not an encoding we know
			default:
			begin
				known = 1'b0;
				writeReg = 1'b0;
				updateFlags = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////
	// Operands and register write
	////////////////////////////////////////

	assign bus.readIdxA = dst;
	assign bus.readIdxB = src;

	assign aluOpOut = opcode;
	assign opA = bus.dataA;
	assign opB = (bSel == instFormatPkg::srcImm) ? dataWidth'(imm) : bus.dataB;
	assign carryIn = status.carry;

	// Write lands on the same edge that registers the result
	assign bus.writeEn = instValid && writeReg;
	assign bus.writeIdx = dst;
	assign bus.writeData = aluResult;

	////////////////////////////////////////
	// Status and result registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			status <= '0;
			resultValid <= 1'b0;
			result <= '0;
			badOp <= 1'b0;
		end
		else
		begin
			resultValid <= instValid;
			badOp <= instValid && !known;
			if (instValid)
				result <= known ? aluResult : '0;
			if (instValid && updateFlags)
				status <= aluFlagsIn;
		end
	end

	assign flags = status;

endmodule

//--- source/execUnit.sv
`timescale 1ns/1ns

module execUnit #(
	parameter int dataWidth = 16,
	parameter int regCount = 16
)(
	input logic clk,
	input logic rst,
	input logic instValid,
	input aluOpsPkg::aluOp opcode,
	input instFormatPkg::regIndex dst,
	input instFormatPkg::regIndex src,
	input instFormatPkg::immWord imm,
	output logic resultValid,
	output logic [dataWidth-1:0] result,
	output aluOpsPkg::aluFlags flags,
	output logic badOp
);

	aluOpsPkg::aluOp aluOpSel;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic carryIn;
	logic [dataWidth-1:0] aluResult;
	aluOpsPkg::aluFlags aluFlagsOut;

	// Register file port bundle
	regBusIf #(
		.dataWidth(dataWidth),
		.regCount (regCount)
	) regBus ();

	registerFile #(
		.dataWidth(dataWidth),
		.regCount (regCount)
	) regFile (
		.clk(clk),
		.rst(rst),
		.bus(regBus.store)
	);

	execControl #(
		.dataWidth(dataWidth)
	) control (
		.clk        (clk),
		.rst        (rst),
		.instValid  (instValid),
		.opcode     (opcode),
		.dst        (dst),
		.src        (src),
		.imm        (imm),
		.bus        (regBus.client),
		.aluOpOut   (aluOpSel),
		.opA        (opA),
		.opB        (opB),
		.carryIn    (carryIn),
		.aluResult  (aluResult),
		.aluFlagsIn (aluFlagsOut),
		.resultValid(resultValid),
		.result     (result),
		.flags      (flags),
		.badOp      (badOp)
	);

	alu #(
		.dataWidth(dataWidth)
	) aluUnit (
		.op     (aluOpSel),
		.a      (opA),
		.b      (opB),
		.carryIn(carryIn),
		.result (aluResult),
		.flags  (aluFlagsOut)
	);

endmodule

//--- source/instFormatPkg.sv
package instFormatPkg;

	////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////

	// Sixteen registers addressed by dst and src
	localparam int regIndexWidth = 4;

	// Immediate is a full data word
	localparam int immWidth = 16;

	typedef logic [regIndexWidth-1:0] regIndex;

	typedef logic [immWidth-1:0] immWord;

	// Source of the second ALU operand
	typedef enum logic {
		srcReg = 1'b0,
		srcImm = 1'b1
	} operandSrc;

endpackage

//--- source/regBusIf.sv
`timescale 1ns/1ns

interface regBusIf #(
	parameter int dataWidth = 16,
	parameter int regCount = 16
);

	localparam int idxWidth = $clog2(regCount);

	// Two read ports
	logic [idxWidth-1:0] readIdxA;
	logic [idxWidth-1:0] readIdxB;
	logic [dataWidth-1:0] dataA;
	logic [dataWidth-1:0] dataB;

	// One write port
	logic writeEn;
	logic [idxWidth-1:0] writeIdx;
	logic [dataWidth-1:0] writeData;

	modport store (
		input readIdxA,
		input readIdxB,
		input writeEn,
		input writeIdx,
		input writeData,
		output dataA,
		output dataB
	);

	modport client (
		output readIdxA,
		output readIdxB,
		output writeEn,
		output writeIdx,
		output writeData,
		input dataA,
		input dataB
	);

endinterface

//--- source/registerFile.sv
`timescale 1ns/1ns

module registerFile #(
	parameter int dataWidth = 16,
	parameter int regCount = 16
)(
	input logic clk,
	input logic rst,
	regBusIf.store bus
);

	logic [dataWidth-1:0] regs [regCount];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// All registers start at zero
			for (int i = 0; i < regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (bus.writeEn)
		begin
			regs[bus.writeIdx] <= bus.writeData;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// Combinational, a write shows up after the edge
	assign bus.dataA = regs[bus.readIdxA];
	assign bus.dataB = regs[bus.readIdxB];

endmodule
